/* hdl/rename_pkg.sv */
package rename_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Lanes renamed per cycle
  localparam int RENAME_WIDTH = 2;

  localparam int ARF_COUNT = 32;
  localparam int PRF_COUNT = 64;

  // Every physical register not named by the map sits in the free list
  localparam int FREE_DEPTH = PRF_COUNT - ARF_COUNT;

  localparam int CP_COUNT = 4;

  localparam int ARF_BITS      = $clog2(ARF_COUNT);
  localparam int PRF_BITS      = $clog2(PRF_COUNT);
  localparam int FREE_PTR_BITS = $clog2(FREE_DEPTH) + 1;
  localparam int CP_BITS       = $clog2(CP_COUNT);

  ////////////////////////////////////////
  // Index types
  ////////////////////////////////////////

  typedef logic [ARF_BITS-1:0] arf_idx_t;
  typedef logic [PRF_BITS-1:0] prf_idx_t;

  // Slot index plus wrap bit
  typedef logic [FREE_PTR_BITS-1:0] free_ptr_t;
  typedef logic [FREE_PTR_BITS-2:0] free_slot_t;

  typedef logic [CP_BITS-1:0] cp_idx_t;
  typedef logic [CP_BITS:0]   cp_count_t;

  // Whole architectural to physical map
  typedef prf_idx_t [ARF_COUNT-1:0] map_t;

  // Operation of the checkpoint unit in one cycle
  typedef enum logic [1:0] {
    CP_IDLE,
    CP_TAKE,
    CP_RECOVER,
    CP_RESOLVE
  } cp_state_e;

endpackage

/* hdl/rename_if.sv */
`timescale 1ns/1ps

// Allocation, release and head pointer traffic around the free list
interface free_list_if;

  logic      [rename_pkg::RENAME_WIDTH-1:0]                       alloc;
  rename_pkg::prf_idx_t [rename_pkg::RENAME_WIDTH-1:0]            alloc_prf;
  logic                                                           allocatable;
  logic      [rename_pkg::RENAME_WIDTH-1:0]                       release_valid;
  rename_pkg::prf_idx_t [rename_pkg::RENAME_WIDTH-1:0]            release_prf;
  rename_pkg::free_ptr_t                                          head;
  rename_pkg::free_ptr_t                                          head_restore;
  // Load head_restore into the head
  logic                                                           restore;

  modport fl (
    input  alloc, release_valid, release_prf, head_restore, restore,
    output alloc_prf, allocatable, head
  );

  modport mt (
    input  alloc_prf, allocatable,
    output alloc
  );

  modport cp (
    input  head, alloc,
    output head_restore, restore
  );

endinterface

// Snapshot and restore of the map between map table and checkpoint store
interface checkpoint_if;

  logic                take;
  rename_pkg::map_t    map_next;
  rename_pkg::cp_idx_t take_id;
  logic                checkable;
  logic                recover;
  rename_pkg::cp_idx_t recover_id;
  rename_pkg::map_t    map_restore;

  modport mt (
    input  checkable, recover, map_restore,
    output take, map_next
  );

  modport cp (
    input  take, map_next, recover, recover_id,
    output take_id, checkable, map_restore
  );

endinterface

/* hdl/map_table.sv */
`timescale 1ns/1ps

module map_table (
  input  logic                                                clock,
  input  logic                                                reset,

  input  logic                                                rename_valid,
  input  logic                 [rename_pkg::RENAME_WIDTH-1:0] rd_valid,
  input  logic                                                checkpoint_req,

  input  rename_pkg::arf_idx_t [rename_pkg::RENAME_WIDTH-1:0] rs1,
  input  rename_pkg::arf_idx_t [rename_pkg::RENAME_WIDTH-1:0] rs2,
  input  rename_pkg::arf_idx_t [rename_pkg::RENAME_WIDTH-1:0] rd,

  output rename_pkg::prf_idx_t [rename_pkg::RENAME_WIDTH-1:0] prs1,
  output rename_pkg::prf_idx_t [rename_pkg::RENAME_WIDTH-1:0] prs2,
  output rename_pkg::prf_idx_t [rename_pkg::RENAME_WIDTH-1:0] prd,
  output rename_pkg::prf_idx_t [rename_pkg::RENAME_WIDTH-1:0] prev_prd,
  output logic                                                rename_ready,

  free_list_if.mt                                             fl,
  checkpoint_if.mt                                            cp
);

  // Speculative map, one physical tag per architectural register
  rename_pkg::map_t map_q;
  rename_pkg::map_t map_next;

  logic accept;

  ////////////////////////////////////////
  // Destination tags
  ////////////////////////////////////////

  // Lane 1 skips the tag that lane 0 consumes
  always_comb begin
    prd[0] = fl.alloc_prf[0];
    if (rd_valid[0]) begin
      prd[1] = fl.alloc_prf[1];
    end else begin
      prd[1] = fl.alloc_prf[0];
    end
  end

  ////////////////////////////////////////
  // Source lookup and map update
  ////////////////////////////////////////

  // Lanes are walked in program order over a running copy of the map.
  // A younger lane therefore sees the writes of the older lanes of the
  // same group, which covers both RAW and WAW inside the group.
  always_comb begin
    map_next = map_q;
    for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
      prs1[i]     = map_next[rs1[i]];
      prs2[i]     = map_next[rs2[i]];
      prev_prd[i] = map_next[rd[i]];
      if (rd_valid[i]) begin
        map_next[rd[i]] = prd[i];
      end
    end
  end

  ////////////////////////////////////////
  // Accept decision
  ////////////////////////////////////////

  // Needs two free tags, no recover, and a free slot if a snapshot is asked
  assign rename_ready = fl.allocatable && !cp.recover && (!checkpoint_req || cp.checkable);
  assign accept       = rename_valid && rename_ready;

  assign fl.alloc    = {rename_pkg::RENAME_WIDTH{accept}} & rd_valid;
  assign cp.take     = accept && checkpoint_req;
  assign cp.map_next = map_next;

  // Identity map out of reset
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < rename_pkg::ARF_COUNT; i++) begin
        map_q[i] <= rename_pkg::prf_idx_t'(i);
      end
    end else if (cp.recover) begin
      map_q <= cp.map_restore;
    end else if (accept) begin
      map_q <= map_next;
    end
  end

endmodule

/* hdl/free_list.sv */
`timescale 1ns/1ps

module free_list (
  input  logic    clock,
  input  logic    reset,
  free_list_if.fl fl
);

  // Circular queue of free physical tags
  rename_pkg::prf_idx_t  slots [rename_pkg::FREE_DEPTH];

  rename_pkg::free_ptr_t head_ptr;
  rename_pkg::free_ptr_t tail_ptr;
  rename_pkg::free_ptr_t head_next;
  rename_pkg::free_ptr_t tail_next;
  rename_pkg::free_ptr_t free_count;

  // Write position of each release lane
  rename_pkg::free_ptr_t push_ptr [rename_pkg::RENAME_WIDTH];

  ////////////////////////////////////////
  // Pop side
  ////////////////////////////////////////

  // Oldest tags first, in lane order
  always_comb begin
    rename_pkg::free_ptr_t rd_ptr;
    for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
      rd_ptr          = head_ptr + rename_pkg::free_ptr_t'(i);
      fl.alloc_prf[i] = slots[rename_pkg::free_slot_t'(rd_ptr)];
    end
  end

  // Head moves by the number of lanes that took a tag
  always_comb begin
    head_next = head_ptr;
    for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
      if (fl.alloc[i]) begin
        head_next = head_next + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Push side
  ////////////////////////////////////////

  // Retired tags are packed behind the tail in lane order
  always_comb begin
    tail_next = tail_ptr;
    for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
      push_ptr[i] = tail_next;
      if (fl.release_valid[i]) begin
        tail_next = tail_next + 1'b1;
      end
    end
  end

  // Wrap bit makes a full queue distinct from an empty one
  assign free_count     = tail_ptr - head_ptr;
  assign fl.allocatable = free_count >= rename_pkg::free_ptr_t'(rename_pkg::RENAME_WIDTH);
  assign fl.head        = head_ptr;

  always_ff @(posedge clock) begin
    if (reset) begin
      head_ptr <= '0;
      tail_ptr <= rename_pkg::free_ptr_t'(rename_pkg::FREE_DEPTH);
      for (int i = 0; i < rename_pkg::FREE_DEPTH; i++) begin
        slots[i] <= rename_pkg::prf_idx_t'(rename_pkg::ARF_COUNT + i);
      end
    end else begin
      // Rolling the head back hands the squashed tags out again
      if (fl.restore) begin
        head_ptr <= fl.head_restore;
      end else begin
        head_ptr <= head_next;
      end
      tail_ptr <= tail_next;
      for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
        if (fl.release_valid[i]) begin
          slots[rename_pkg::free_slot_t'(push_ptr[i])] <= fl.release_prf[i];
        end
      end
    end
  end

endmodule

/* hdl/checkpoint_unit.sv */
`timescale 1ns/1ps

module checkpoint_unit (
  input  logic     clock,
  input  logic     reset,
  checkpoint_if.cp cp,
  free_list_if.cp  fl,
  input  logic     resolve
);

  // Live slots run from oldest_id for live_count entries, with wrap
  rename_pkg::cp_idx_t   oldest_id;
  rename_pkg::cp_count_t live_count;

  rename_pkg::map_t      snap_map  [rename_pkg::CP_COUNT];
  rename_pkg::free_ptr_t snap_head [rename_pkg::CP_COUNT];

  rename_pkg::cp_state_e op;
  rename_pkg::free_ptr_t head_after;
  rename_pkg::cp_idx_t   recover_dist;
  logic                  resolve_ok;

  // Nothing to free without a live slot
  assign resolve_ok = resolve && (live_count != '0);

  // Recover wins, and a take never comes with it since rename is held
  always_comb begin
    if (cp.recover) begin
      op = rename_pkg::CP_RECOVER;
    end else if (cp.take) begin
      op = rename_pkg::CP_TAKE;
    end else if (resolve_ok) begin
      op = rename_pkg::CP_RESOLVE;
    end else begin
      op = rename_pkg::CP_IDLE;
    end
  end

  // Head after this group's pops
  always_comb begin
    head_after = fl.head;
    for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
      if (fl.alloc[i]) begin
        head_after = head_after + 1'b1;
      end
    end
  end

  assign cp.take_id   = oldest_id + rename_pkg::cp_idx_t'(live_count);
  assign cp.checkable = live_count < rename_pkg::cp_count_t'(rename_pkg::CP_COUNT);

  // recover_id becomes the new tail
  assign recover_dist = cp.recover_id - oldest_id;

  assign cp.map_restore  = snap_map[cp.recover_id];
  assign fl.head_restore = snap_head[cp.recover_id];
  assign fl.restore      = (op == rename_pkg::CP_RECOVER);

  always_ff @(posedge clock) begin
    if (reset) begin
      oldest_id  <= '0;
      live_count <= '0;
    end else begin
      case (op)
        rename_pkg::CP_RECOVER: begin
          live_count <= rename_pkg::cp_count_t'(recover_dist);
        end
        rename_pkg::CP_TAKE: begin
          // Take plus resolve keeps the count and slides the window
          if (resolve_ok) begin
            oldest_id <= oldest_id + 1'b1;
          end else begin
            live_count <= live_count + 1'b1;
          end
        end
        rename_pkg::CP_RESOLVE: begin
          oldest_id  <= oldest_id + 1'b1;
          live_count <= live_count - 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

  // Snapshot storage
  always_ff @(posedge clock) begin
    if (op == rename_pkg::CP_TAKE) begin
      snap_map[cp.take_id]  <= cp.map_next;
      snap_head[cp.take_id] <= head_after;
    end
  end

endmodule

/* hdl/rename_unit.sv */
`timescale 1ns/1ps

module rename_unit (
  input  logic                                                clock,
  input  logic                                                reset,

  // Rename group
  input  logic                                                rename_valid,
  input  logic                 [rename_pkg::RENAME_WIDTH-1:0] rd_valid,
  input  logic                                                checkpoint_req,
  input  rename_pkg::arf_idx_t [rename_pkg::RENAME_WIDTH-1:0] rs1,
  input  rename_pkg::arf_idx_t [rename_pkg::RENAME_WIDTH-1:0] rs2,
  input  rename_pkg::arf_idx_t [rename_pkg::RENAME_WIDTH-1:0] rd,

  // Branch outcome
  input  logic                                                recover,
  input  rename_pkg::cp_idx_t                                 recover_id,
  input  logic                                                resolve,

  // Retirement
  input  logic                 [rename_pkg::RENAME_WIDTH-1:0] retire_valid,
  input  rename_pkg::prf_idx_t [rename_pkg::RENAME_WIDTH-1:0] retire_prf,

  output rename_pkg::prf_idx_t [rename_pkg::RENAME_WIDTH-1:0] prs1,
  output rename_pkg::prf_idx_t [rename_pkg::RENAME_WIDTH-1:0] prs2,
  output rename_pkg::prf_idx_t [rename_pkg::RENAME_WIDTH-1:0] prd,
  output rename_pkg::prf_idx_t [rename_pkg::RENAME_WIDTH-1:0] prev_prd,
  output logic                                                rename_ready,
  output rename_pkg::cp_idx_t                                 checkpoint_id,
  output logic                                                checkable
);

  free_list_if  fl_bus ();
  checkpoint_if cp_bus ();

  // Top level strobes onto the buses
  assign fl_bus.release_valid = retire_valid;
  assign fl_bus.release_prf   = retire_prf;
  assign cp_bus.recover       = recover;
  assign cp_bus.recover_id    = recover_id;

  assign checkpoint_id = cp_bus.take_id;
  assign checkable     = cp_bus.checkable;

  map_table i_map_table (
    .clock          (clock         ),
    .reset          (reset         ),
    .rename_valid   (rename_valid  ),
    .rd_valid       (rd_valid      ),
    .checkpoint_req (checkpoint_req),
    .rs1            (rs1           ),
    .rs2            (rs2           ),
    .rd             (rd            ),
    .prs1           (prs1          ),
    .prs2           (prs2          ),
    .prd            (prd           ),
    .prev_prd       (prev_prd      ),
    .rename_ready   (rename_ready  ),
    .fl             (fl_bus.mt     ),
    .cp             (cp_bus.mt     )
  );

  free_list i_free_list (
    .clock (clock    ),
    .reset (reset    ),
    .fl    (fl_bus.fl)
  );

  checkpoint_unit i_checkpoint_unit (
    .clock   (clock    ),
    .reset   (reset    ),
    .cp      (cp_bus.cp),
    .fl      (fl_bus.cp),
    .resolve (resolve  )
  );

endmodule

/* tests/rename_unit_assert.sv */
`timescale 1ns/1ps

module rename_unit_assert (
  input logic                                                clock,
  input logic                                                reset,
  input logic                                                rename_valid,
  input logic                 [rename_pkg::RENAME_WIDTH-1:0] rd_valid,
  input rename_pkg::prf_idx_t [rename_pkg::RENAME_WIDTH-1:0] prd,
  input logic                                                rename_ready,
  input logic                                                recover,
  input rename_pkg::cp_count_t                               live_count
);

  // No rename while the map is restored
  ready_low_in_recover: assert property (
    @(posedge clock) disable iff (reset) recover |-> !rename_ready
  ) else $error("rename_ready high in a recover cycle");

  // Two destinations of one group never share a tag
  distinct_prd: assert property (
    @(posedge clock) disable iff (reset)
    (rename_valid && rename_ready && (&rd_valid)) |-> (prd[0] != prd[1])
  ) else $error("both lanes got physical register %0d", prd[0]);

  // Takes stop once every slot is live
  live_count_in_range: assert property (
    @(posedge clock) disable iff (reset)
    live_count <= rename_pkg::cp_count_t'(rename_pkg::CP_COUNT)
  ) else $error("%0d live checkpoints", live_count);

endmodule

bind rename_unit rename_unit_assert i_rename_unit_assert (
  .clock        (clock                       ),
  .reset        (reset                       ),
  .rename_valid (rename_valid                ),
  .rd_valid     (rd_valid                    ),
  .prd          (prd                         ),
  .rename_ready (rename_ready                ),
  .recover      (recover                     ),
  .live_count   (i_checkpoint_unit.live_count)
);

/* tests/rename_unit_tb.sv */
`timescale 1ns/1ps

module rename_unit_tb;

  localparam int RESET_CYCLES    = 10;
  localparam int DIRECTED_CYCLES = 60;
  localparam int RANDOM_CYCLES   = 400;
  localparam int W               = rename_pkg::RENAME_WIDTH;
  localparam int FREE_DEPTH      = rename_pkg::FREE_DEPTH;
  localparam int CP_COUNT        = rename_pkg::CP_COUNT;
  localparam time WATCHDOG_TIME  = (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 20) * 40;

  typedef logic [W-1:0] lane_mask_t;

  logic                             clock;
  logic                             reset;
  logic                             rename_valid;
  lane_mask_t                       rd_valid;
  logic                             checkpoint_req;
  rename_pkg::arf_idx_t [W-1:0]     rs1;
  rename_pkg::arf_idx_t [W-1:0]     rs2;
  rename_pkg::arf_idx_t [W-1:0]     rd;
  logic                             recover;
  rename_pkg::cp_idx_t              recover_id;
  logic                             resolve;
  lane_mask_t                       retire_valid;
  rename_pkg::prf_idx_t [W-1:0]     retire_prf;
  rename_pkg::prf_idx_t [W-1:0]     prs1;
  rename_pkg::prf_idx_t [W-1:0]     prs2;
  rename_pkg::prf_idx_t [W-1:0]     prd;
  rename_pkg::prf_idx_t [W-1:0]     prev_prd;
  logic                             rename_ready;
  rename_pkg::cp_idx_t              checkpoint_id;
  logic                             checkable;

  ////////////////////////////////////////
  // Reference model state
  ////////////////////////////////////////

  int map_m   [rename_pkg::ARF_COUNT];
  int fq      [FREE_DEPTH];
  int fq_head;
  int fq_tail;
  int cp_oldest;
  int cp_live;
  int cp_map  [CP_COUNT][rename_pkg::ARF_COUNT];
  int cp_head [CP_COUNT];
  // Sequence number of the group that took each checkpoint
  int cp_seq  [CP_COUNT];
  int group_seq;
  // Groups not yet retired, -1 for a lane without destination
  int pend_seq [$];
  int pend_t0  [$];
  int pend_t1  [$];

  int   exp_prs1 [W];
  int   exp_prs2 [W];
  int   exp_prd  [W];
  int   exp_prev [W];
  int   exp_map  [rename_pkg::ARF_COUNT];
  int   exp_used;
  logic exp_ready;

  int seed;
  int checks;
  int mismatches;
  int other_errors;
  bit retire_on;
  bit saw_stall;
  bit saw_cp_full;

  rename_unit i_rename_unit (.*);

  always #20 clock = ~clock;

  function automatic int rnd(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Expected outputs of the group on the inputs right now
  function automatic void predict();
    int used;
    exp_map = map_m;
    used    = 0;
    for (int i = 0; i < W; i++) begin
      exp_prs1[i] = exp_map[rs1[i]];
      exp_prs2[i] = exp_map[rs2[i]];
      exp_prev[i] = exp_map[rd[i]];
      // Each lane takes the first tag the older lanes left
      exp_prd[i]  = fq[(fq_head + used) % FREE_DEPTH];
      if (rd_valid[i]) begin
        exp_map[rd[i]] = exp_prd[i];
        used++;
      end
    end
    exp_used  = used;
    exp_ready = (fq_tail - fq_head >= W) && !recover && (!checkpoint_req || cp_live < CP_COUNT);
  endfunction

  task automatic init_model();
    for (int i = 0; i < rename_pkg::ARF_COUNT; i++) begin
      map_m[i] = i;
    end
    for (int i = 0; i < FREE_DEPTH; i++) begin
      fq[i] = rename_pkg::ARF_COUNT + i;
    end
    fq_head   = 0;
    fq_tail   = FREE_DEPTH;
    cp_oldest = 0;
    cp_live   = 0;
    group_seq = 0;
  endtask

  // Advance the model across one rising edge
  task automatic commit();
    int  slot;
    logic resolve_ok;
    resolve_ok = resolve && (cp_live > 0);
    if (recover) begin
      slot    = recover_id;
      map_m   = cp_map[slot];
      fq_head = cp_head[slot];
      while (pend_seq.size() > 0 && pend_seq[$] > cp_seq[slot]) begin
        void'(pend_seq.pop_back());
        void'(pend_t0.pop_back());
        void'(pend_t1.pop_back());
      end
      cp_live = (slot - cp_oldest + CP_COUNT) % CP_COUNT;
    end else begin
      if (rename_valid && exp_ready) begin
        map_m   = exp_map;
        fq_head = fq_head + exp_used;
        group_seq++;
        if (rd_valid != '0) begin
          pend_seq.push_back(group_seq);
          pend_t0.push_back(rd_valid[0] ? exp_prev[0] : -1);
          pend_t1.push_back(rd_valid[1] ? exp_prev[1] : -1);
        end
        if (checkpoint_req) begin
          slot          = (cp_oldest + cp_live) % CP_COUNT;
          cp_map[slot]  = exp_map;
          cp_head[slot] = fq_head;
          cp_seq[slot]  = group_seq;
          cp_live++;
        end
      end
      if (resolve_ok) begin
        cp_oldest = (cp_oldest + 1) % CP_COUNT;
        cp_live--;
      end
    end
    for (int i = 0; i < W; i++) begin
      if (retire_valid[i]) begin
        fq[fq_tail % FREE_DEPTH] = retire_prf[i];
        fq_tail++;
      end
    end
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    if (expected != actual) begin
      mismatches++;
      $display("MISMATCH at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  ////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////

  // Outputs settle in the low phase and are sampled as the edge commits them
  always @(posedge clock) begin
    if (!reset) begin
      predict();
      for (int i = 0; i < W; i++) begin
        check_value($sformatf("prs1[%0d]", i), exp_prs1[i], int'(prs1[i]));
        check_value($sformatf("prs2[%0d]", i), exp_prs2[i], int'(prs2[i]));
        check_value($sformatf("prev_prd[%0d]", i), exp_prev[i], int'(prev_prd[i]));
        if (exp_ready) begin
          check_value($sformatf("prd[%0d]", i), exp_prd[i], int'(prd[i]));
        end
      end
      check_value("rename_ready", int'(exp_ready), int'(rename_ready));
      check_value("checkpoint_id", (cp_oldest + cp_live) % CP_COUNT, int'(checkpoint_id));
      check_value("checkable", int'(cp_live < CP_COUNT), int'(checkable));
      if (rename_valid && (fq_tail - fq_head < W)) begin
        saw_stall = 1'b1;
      end
      if (rename_valid && checkpoint_req && cp_live == CP_COUNT) begin
        saw_cp_full = 1'b1;
      end
      commit();
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Retire the oldest group once no live checkpoint is older
  task automatic choose_retire();
    int t0;
    int t1;
    if (pend_seq.size() > 0 && (cp_live == 0 || pend_seq[0] <= cp_seq[cp_oldest])) begin
      void'(pend_seq.pop_front());
      t0 = pend_t0.pop_front();
      t1 = pend_t1.pop_front();
      retire_valid[0] = (t0 >= 0);
      retire_valid[1] = (t1 >= 0);
      retire_prf[0]   = rename_pkg::prf_idx_t'(t0);
      retire_prf[1]   = rename_pkg::prf_idx_t'(t1);
    end
  endtask

  task automatic start_cycle();
    @(negedge clock);
    rename_valid   = 1'b0;
    rd_valid       = '0;
    checkpoint_req = 1'b0;
    recover        = 1'b0;
    recover_id     = '0;
    resolve        = 1'b0;
    retire_valid   = '0;
    retire_prf     = '0;
    for (int i = 0; i < W; i++) begin
      rs1[i] = rename_pkg::arf_idx_t'(rnd(rename_pkg::ARF_COUNT));
      rs2[i] = rename_pkg::arf_idx_t'(rnd(rename_pkg::ARF_COUNT));
      rd[i]  = rename_pkg::arf_idx_t'(rnd(rename_pkg::ARF_COUNT));
    end
    if (retire_on && rnd(4) != 0) begin
      choose_retire();
    end
  endtask

  task automatic rename_group(input lane_mask_t lanes, input logic take_cp);
    start_cycle();
    rename_valid   = 1'b1;
    rd_valid       = lanes;
    checkpoint_req = take_cp;
  endtask

  task automatic random_cycle();
    rename_group(lane_mask_t'(rnd(4)), rnd(4) == 0);
    rename_valid = (rnd(4) != 0);
    if (cp_live > 0 && rnd(16) == 0) begin
      recover    = 1'b1;
      recover_id = rename_pkg::cp_idx_t'((cp_oldest + rnd(cp_live)) % CP_COUNT);
    end else if (cp_live > 0 && rnd(6) == 0) begin
      resolve = 1'b1;
    end
  endtask

  initial begin
    seed           = 32'h126a_c5ec;
    clock          = 1'b0;
    reset          = 1'b1;
    rename_valid   = 1'b0;
    rd_valid       = '0;
    checkpoint_req = 1'b0;
    rs1            = '0;
    rs2            = '0;
    rd             = '0;
    recover        = 1'b0;
    recover_id     = '0;
    resolve        = 1'b0;
    retire_valid   = '0;
    retire_prf     = '0;
    checks         = 0;
    mismatches     = 0;
    other_errors   = 0;
    retire_on      = 1'b0;
    saw_stall      = 1'b0;
    saw_cp_full    = 1'b0;
    init_model();
    repeat (RESET_CYCLES) @(negedge clock);
    reset = 1'b0;

    // Single lane groups from the identity map
    repeat (4) rename_group(2'b01, 1'b0);
    // Lane 1 reads, then overwrites, lane 0's destination
    rename_group(2'b11, 1'b0);
    rs1[1] = rd[0];
    rs2[1] = rd[0];
    rename_group(2'b11, 1'b0);
    rd[1] = rd[0];
    // Drain the free list, then retire until groups flow again
    repeat (16) rename_group(2'b11, 1'b0);
    retire_on = 1'b1;
    repeat (12) start_cycle();
    repeat (4) rename_group(2'b11, 1'b0);
    // Four checkpoints fill the store and the fifth waits for a resolve
    repeat (5) rename_group(2'b01, 1'b1);
    rename_group(2'b01, 1'b1);
    resolve = 1'b1;
    rename_group(2'b01, 1'b1);
    // Recover to the second live checkpoint, then reuse the freed ids
    repeat (2) rename_group(2'b11, 1'b0);
    start_cycle();
    recover    = 1'b1;
    recover_id = rename_pkg::cp_idx_t'((cp_oldest + 1) % CP_COUNT);
    repeat (3) rename_group(2'b11, 1'b1);

    repeat (RANDOM_CYCLES) random_cycle();
    start_cycle();
    @(negedge clock);

    if (!saw_stall) begin
      other_errors++;
      $display("Error: the free list never ran short of tags");
    end
    if (!saw_cp_full) begin
      other_errors++;
      $display("Error: no checkpoint request met a full checkpoint store");
    end
    $display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches,
             other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_TIME);
    $display("Timeout: stimulus did not finish within %0d ns", WATCHDOG_TIME);
    $display("Testbench failed");
    $finish;
  end

endmodule

/* verilog.f */
hdl/rename_pkg.sv
hdl/rename_if.sv
hdl/map_table.sv
hdl/free_list.sv
hdl/checkpoint_unit.sv
hdl/rename_unit.sv
tests/rename_unit_assert.sv
tests/rename_unit_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= rename_unit_tb
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Testbench failed
PASS_MSG   ?= Testbench passed
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early, see $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
